// ==== design/adc_stream_pkg.sv ====
package adc_stream_pkg;

    // bus widths
    localparam int S_DATA_WIDTH = 128;
    localparam int M_DATA_WIDTH = 64;

    // one input beat carries eight 16-bit slots
    localparam int SLOT_WIDTH = 16;
    localparam int SAMPLES_PER_BEAT = 8;

    // adc code sits in the low bits of a slot
    localparam int ADC_WIDTH = 12;

    // timestamp and event number
    localparam int STAMP_WIDTH = 16;
    localparam int EVENT_WIDTH = 16;

    // header word field positions, other bits zero
    localparam int HDR_STAMP_LSB = 0;
    localparam int HDR_EVENT_LSB = 16;
    localparam int HDR_BASE_LSB = 32;

endpackage

// ==== design/trigger_ctrl_pkg.sv ====
package trigger_ctrl_pkg;

    // trigger state machine
    typedef enum logic [1:0]
    {
        CALIB   = 2'd0,
        ARMED   = 2'd1,
        CAPTURE = 2'd2,
        REARM   = 2'd3
    } trig_state_t;

    // tag on each event fifo entry
    // a header entry yields one output word, a samples entry two
    typedef enum logic
    {
        HEADER  = 1'b0,
        SAMPLES = 1'b1
    } entry_kind_t;

endpackage

// ==== design/baseline_tracker.sv ====
`timescale 1ns/10ps

module baseline_tracker #(
    parameter int BASELINE_LOG2 = 4
) (
    input  logic                                  axis_aclk,
    input  logic                                  rst,
    input  logic [adc_stream_pkg::S_DATA_WIDTH-1:0] s_axis_tdata,
    input  logic                                  s_axis_tvalid,
    output logic                                  s_axis_tready,
    output logic [adc_stream_pkg::S_DATA_WIDTH-1:0] beat_data,
    output logic                                  beat_strobe,
    output logic [adc_stream_pkg::ADC_WIDTH-1:0]    beat_max,
    output logic [adc_stream_pkg::ADC_WIDTH-1:0]    baseline,
    output logic                                  baseline_ready
);
    import adc_stream_pkg::*;

    localparam int SUM_WIDTH = ADC_WIDTH + BASELINE_LOG2;

    logic                 accept;
    logic [ADC_WIDTH-1:0] in_min;
    logic [ADC_WIDTH-1:0] in_max;
    logic [ADC_WIDTH-1:0] beat_min;
    logic [SUM_WIDTH-1:0] base_sum;
    logic [SUM_WIDTH-1:0] sum_next;
    logic [BASELINE_LOG2:0] calib_count;

    // the converter is never stalled
    assign s_axis_tready = !rst;
    assign accept = s_axis_tvalid && s_axis_tready;

    // smallest and largest code of the incoming beat
    always_comb
    begin
        logic [ADC_WIDTH-1:0] code;
        in_min = '1;
        in_max = '0;
        for (int i = 0; i < SAMPLES_PER_BEAT; i++)
        begin
            code = s_axis_tdata[i*SLOT_WIDTH +: ADC_WIDTH];
            if (code < in_min)
                in_min = code;
            if (code > in_max)
                in_max = code;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (accept)
        begin
            beat_data <= s_axis_tdata;
            beat_min  <= in_min;
            beat_max  <= in_max;
        end
        if (rst)
            beat_strobe <= 1'b0;
        else
            beat_strobe <= accept;
    end

    assign sum_next = base_sum + SUM_WIDTH'(beat_min);

    // sum the minima of the first 2^BASELINE_LOG2 beats, then hold the mean
    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            base_sum       <= '0;
            calib_count    <= '0;
            baseline_ready <= 1'b0;
        end
        else if (beat_strobe && !baseline_ready)
        begin
            base_sum    <= sum_next;
            calib_count <= calib_count + 1'b1;
            if (calib_count == (2**BASELINE_LOG2) - 1)
            begin
                baseline       <= sum_next[SUM_WIDTH-1 -: ADC_WIDTH];
                baseline_ready <= 1'b1;
            end
        end
    end

endmodule

// ==== design/pretrigger_buffer.sv ====
`timescale 1ns/10ps

module pretrigger_buffer #(
    parameter int PRE_LEN = 4
) (
    input  logic                                  axis_aclk,
    input  logic                                  rst,
    input  logic [adc_stream_pkg::S_DATA_WIDTH-1:0] beat_data,
    input  logic                                  beat_strobe,
    input  logic                                  replay_start,
    output logic [adc_stream_pkg::S_DATA_WIDTH-1:0] replay_data,
    output logic                                  replay_strobe
);
    import adc_stream_pkg::*;

    // one slot beyond PRE_LEN keeps the trigger beat as well
    localparam int RING_LEN = PRE_LEN + 1;
    localparam int PTR_WIDTH = $clog2(RING_LEN + 1);

    logic [S_DATA_WIDTH-1:0] ring [RING_LEN];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH-1:0] rd_addr;
    logic [PTR_WIDTH-1:0] replay_left;

    function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] p);
        return (p == PTR_WIDTH'(RING_LEN - 1)) ? '0 : p + 1'b1;
    endfunction

    // at replay_start the oldest stored beat sits at the write pointer
    assign rd_addr = replay_start ? wr_ptr : rd_ptr;

    always_ff @(posedge axis_aclk)
    begin
        if (beat_strobe)
            ring[wr_ptr] <= beat_data;
        if (replay_start || replay_left != 0)
            replay_data <= ring[rd_addr];
    end

    // reads stay one slot ahead of the overwrites
    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            replay_left   <= '0;
            replay_strobe <= 1'b0;
        end
        else
        begin
            if (beat_strobe)
                wr_ptr <= ptr_next(wr_ptr);
            if (replay_start || replay_left != 0)
            begin
                replay_strobe <= 1'b1;
                rd_ptr        <= ptr_next(rd_addr);
                replay_left   <= replay_start ? PTR_WIDTH'(PRE_LEN - 1) : replay_left - 1'b1;
            end
            else
                replay_strobe <= 1'b0;
        end
    end

endmodule

// ==== design/trigger_sequencer.sv ====
`timescale 1ns/10ps

module trigger_sequencer #(
    parameter int THRESHOLD  = 400,
    parameter int PRE_LEN    = 4,
    parameter int POST_LEN   = 6,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                                  axis_aclk,
    input  logic                                  rst,
    input  logic [adc_stream_pkg::S_DATA_WIDTH-1:0] beat_data,
    input  logic                                  beat_strobe,
    input  logic [adc_stream_pkg::ADC_WIDTH-1:0]    beat_max,
    input  logic [adc_stream_pkg::ADC_WIDTH-1:0]    baseline,
    input  logic                                  baseline_ready,
    input  logic [adc_stream_pkg::S_DATA_WIDTH-1:0] replay_data,
    input  logic                                  replay_strobe,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]       free_entries,
    output logic                                  replay_start,
    output logic                                  entry_write,
    output trigger_ctrl_pkg::entry_kind_t         entry_kind,
    output logic [adc_stream_pkg::S_DATA_WIDTH-1:0] entry_data,
    output logic                                  entry_last,
    output logic [15:0]                           dropped_events
);
    import adc_stream_pkg::*;
    import trigger_ctrl_pkg::*;

    localparam int EVENT_ENTRIES = PRE_LEN + POST_LEN + 2;
    // live beats wait until the replay has been written
    localparam int DELAY = PRE_LEN + 2;
    localparam int POST_WIDTH = $clog2(POST_LEN + 2);

    trig_state_t             state;
    logic [STAMP_WIDTH-1:0]  beat_stamp;
    logic [EVENT_WIDTH-1:0]  event_num;
    logic [ADC_WIDTH:0]      trig_level;
    logic                    over_level;
    logic                    trigger;
    logic                    fits;
    logic [S_DATA_WIDTH-1:0] header;
    logic [S_DATA_WIDTH-1:0] hold_data [DELAY];
    logic [DELAY-1:0]        hold_valid;
    logic [DELAY-1:0]        hold_mark;
    logic [POST_WIDTH-1:0]   post_left;

    assign trig_level = {1'b0, baseline} + (ADC_WIDTH + 1)'(THRESHOLD);
    assign over_level = {1'b0, beat_max} > trig_level;
    assign trigger = (state == ARMED) && beat_strobe && over_level;
    assign fits = free_entries >= EVENT_ENTRIES;

    always_comb
    begin
        header = '0;
        header[HDR_STAMP_LSB +: STAMP_WIDTH] = beat_stamp;
        header[HDR_EVENT_LSB +: EVENT_WIDTH] = event_num;
        header[HDR_BASE_LSB +: ADC_WIDTH] = baseline;
    end

    // holding line for live beats, the trigger beat carries a mark
    always_ff @(posedge axis_aclk)
    begin
        hold_data[0] <= beat_data;
        for (int i = 1; i < DELAY; i++)
            hold_data[i] <= hold_data[i-1];
        if (rst)
        begin
            hold_valid <= '0;
            hold_mark  <= '0;
        end
        else
        begin
            hold_valid <= {hold_valid[DELAY-2:0], beat_strobe};
            hold_mark  <= {hold_mark[DELAY-2:0], trigger && fits};
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            state          <= CALIB;
            beat_stamp     <= '0;
            event_num      <= '0;
            dropped_events <= '0;
            replay_start   <= 1'b0;
            entry_write    <= 1'b0;
            entry_last     <= 1'b0;
            post_left      <= '0;
        end
        else
        begin
            replay_start <= 1'b0;
            entry_write  <= 1'b0;
            entry_last   <= 1'b0;
            if (beat_strobe)
                beat_stamp <= beat_stamp + 1'b1;
            case (state)
                CALIB:
                    if (baseline_ready)
                        state <= ARMED;
                ARMED:
                    if (trigger && fits)
                    begin
                        entry_write  <= 1'b1;
                        entry_kind   <= HEADER;
                        entry_data   <= header;
                        replay_start <= 1'b1;
                        event_num    <= event_num + 1'b1;
                        state        <= CAPTURE;
                    end
                    else if (trigger)
                    begin
                        // whole event dropped
                        dropped_events <= dropped_events + 1'b1;
                        state          <= REARM;
                    end
                CAPTURE:
                    if (replay_strobe)
                    begin
                        entry_write <= 1'b1;
                        entry_kind  <= SAMPLES;
                        entry_data  <= replay_data;
                    end
                    else if (hold_valid[DELAY-1] && (hold_mark[DELAY-1] || post_left != 0))
                    begin
                        entry_write <= 1'b1;
                        entry_kind  <= SAMPLES;
                        entry_data  <= hold_data[DELAY-1];
                        if (hold_mark[DELAY-1])
                            post_left <= POST_WIDTH'(POST_LEN);
                        else
                            post_left <= post_left - 1'b1;
                        if (hold_mark[DELAY-1] ? (POST_LEN == 0) : (post_left == 1))
                        begin
                            entry_last <= 1'b1;
                            state      <= REARM;
                        end
                    end
                REARM:
                    if (beat_strobe && !over_level)
                        state <= ARMED;
                default:
                    state <= CALIB;
            endcase
        end
    end

endmodule

// ==== design/event_packer.sv ====
`timescale 1ns/10ps

module event_packer #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                                  axis_aclk,
    input  logic                                  rst,
    input  logic                                  entry_write,
    input  trigger_ctrl_pkg::entry_kind_t         entry_kind,
    input  logic [adc_stream_pkg::S_DATA_WIDTH-1:0] entry_data,
    input  logic                                  entry_last,
    input  logic                                  m_axis_tready,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]       free_entries,
    output logic                                  fifo_full,
    output logic [adc_stream_pkg::M_DATA_WIDTH-1:0] m_axis_tdata,
    output logic                                  m_axis_tvalid,
    output logic                                  m_axis_tlast,
    output logic                                  m_axis_tuser
);
    import adc_stream_pkg::*;
    import trigger_ctrl_pkg::*;

    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    logic [S_DATA_WIDTH-1:0] mem_data [FIFO_DEPTH];
    entry_kind_t             mem_kind [FIFO_DEPTH];
    logic                    mem_last [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]    wr_ptr;
    logic [PTR_WIDTH-1:0]    rd_ptr;
    logic [CNT_WIDTH-1:0]    count;

    // entry being split into output words
    logic [S_DATA_WIDTH-1:0] ent_data;
    entry_kind_t             ent_kind;
    logic                    ent_last;
    logic                    ent_valid;
    logic                    ent_upper;

    logic out_advance;
    logic ent_done;
    logic pop;

    function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] p);
        return (p == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign free_entries = CNT_WIDTH'(FIFO_DEPTH) - count;
    assign fifo_full = (free_entries == 0);

    // output word moves when the slot is empty or being taken
    assign out_advance = !m_axis_tvalid || m_axis_tready;
    assign ent_done = ent_valid && out_advance && (ent_kind == HEADER || ent_upper);
    assign pop = (count != 0) && (!ent_valid || ent_done);

    always_ff @(posedge axis_aclk)
    begin
        if (entry_write)
        begin
            mem_data[wr_ptr] <= entry_data;
            mem_kind[wr_ptr] <= entry_kind;
            mem_last[wr_ptr] <= entry_last;
        end
        if (pop)
        begin
            ent_data <= mem_data[rd_ptr];
            ent_kind <= mem_kind[rd_ptr];
            ent_last <= mem_last[rd_ptr];
        end
        if (out_advance && ent_valid)
            m_axis_tdata <= ent_upper ? ent_data[S_DATA_WIDTH-1 -: M_DATA_WIDTH]
                                      : ent_data[M_DATA_WIDTH-1:0];
    end

    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (entry_write)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            count <= count + CNT_WIDTH'(entry_write) - CNT_WIDTH'(pop);
        end
    end

    // half select and output register
    always_ff @(posedge axis_aclk)
    begin
        if (rst)
        begin
            ent_valid     <= 1'b0;
            ent_upper     <= 1'b0;
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
            m_axis_tuser  <= 1'b0;
        end
        else
        begin
            if (out_advance)
            begin
                m_axis_tvalid <= ent_valid;
                m_axis_tuser  <= ent_valid && (ent_kind == HEADER);
                m_axis_tlast  <= ent_valid && ent_upper && ent_last;
            end
            if (pop)
            begin
                ent_valid <= 1'b1;
                ent_upper <= 1'b0;
            end
            else if (ent_done)
                ent_valid <= 1'b0;
            else if (ent_valid && out_advance)
                ent_upper <= 1'b1;
        end
    end

endmodule

// ==== design/mm_trigger_top.sv ====
`timescale 1ns/10ps

module mm_trigger_top #(
    parameter int THRESHOLD     = 400,
    parameter int BASELINE_LOG2 = 4,
    parameter int PRE_LEN       = 4,
    parameter int POST_LEN      = 6,
    parameter int FIFO_DEPTH    = 16
) (
    input  logic                                  axis_aclk,
    input  logic                                  rst,
    input  logic [adc_stream_pkg::S_DATA_WIDTH-1:0] s_axis_tdata,
    input  logic                                  s_axis_tvalid,
    output logic                                  s_axis_tready,
    output logic [adc_stream_pkg::M_DATA_WIDTH-1:0] m_axis_tdata,
    output logic                                  m_axis_tvalid,
    input  logic                                  m_axis_tready,
    output logic                                  m_axis_tlast,
    output logic                                  m_axis_tuser,
    output logic                                  fifo_full,
    output logic [15:0]                           dropped_events
);
    import adc_stream_pkg::*;
    import trigger_ctrl_pkg::*;

    localparam int FREE_WIDTH = $clog2(FIFO_DEPTH + 1);

    logic [S_DATA_WIDTH-1:0] beat_data;
    logic                    beat_strobe;
    logic [ADC_WIDTH-1:0]    beat_max;
    logic [ADC_WIDTH-1:0]    baseline;
    logic                    baseline_ready;
    logic                    replay_start;
    logic [S_DATA_WIDTH-1:0] replay_data;
    logic                    replay_strobe;
    logic                    entry_write;
    entry_kind_t             entry_kind;
    logic [S_DATA_WIDTH-1:0] entry_data;
    logic                    entry_last;
    logic [FREE_WIDTH-1:0]   free_entries;

    baseline_tracker #(
        .BASELINE_LOG2(BASELINE_LOG2)
    ) baseline_tracker_inst (
        .axis_aclk     (axis_aclk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .beat_data     (beat_data),
        .beat_strobe   (beat_strobe),
        .beat_max      (beat_max),
        .baseline      (baseline),
        .baseline_ready(baseline_ready)
    );

    pretrigger_buffer #(
        .PRE_LEN(PRE_LEN)
    ) pretrigger_buffer_inst (
        .axis_aclk    (axis_aclk),
        .rst          (rst),
        .beat_data    (beat_data),
        .beat_strobe  (beat_strobe),
        .replay_start (replay_start),
        .replay_data  (replay_data),
        .replay_strobe(replay_strobe)
    );

    trigger_sequencer #(
        .THRESHOLD (THRESHOLD),
        .PRE_LEN   (PRE_LEN),
        .POST_LEN  (POST_LEN),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) trigger_sequencer_inst (
        .axis_aclk     (axis_aclk),
        .rst           (rst),
        .beat_data     (beat_data),
        .beat_strobe   (beat_strobe),
        .beat_max      (beat_max),
        .baseline      (baseline),
        .baseline_ready(baseline_ready),
        .replay_data   (replay_data),
        .replay_strobe (replay_strobe),
        .free_entries  (free_entries),
        .replay_start  (replay_start),
        .entry_write   (entry_write),
        .entry_kind    (entry_kind),
        .entry_data    (entry_data),
        .entry_last    (entry_last),
        .dropped_events(dropped_events)
    );

    event_packer #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) event_packer_inst (
        .axis_aclk    (axis_aclk),
        .rst          (rst),
        .entry_write  (entry_write),
        .entry_kind   (entry_kind),
        .entry_data   (entry_data),
        .entry_last   (entry_last),
        .m_axis_tready(m_axis_tready),
        .free_entries (free_entries),
        .fifo_full    (fifo_full),
        .m_axis_tdata (m_axis_tdata),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tlast (m_axis_tlast),
        .m_axis_tuser (m_axis_tuser)
    );

endmodule

// ==== tests/mm_trigger_assert.sv ====
`timescale 1ns/10ps

module mm_trigger_assert (
    input logic                                  axis_aclk,
    input logic                                  rst,
    input logic                                  s_axis_tready,
    input logic [adc_stream_pkg::M_DATA_WIDTH-1:0] m_axis_tdata,
    input logic                                  m_axis_tvalid,
    input logic                                  m_axis_tready,
    input logic                                  m_axis_tlast,
    input logic                                  m_axis_tuser
);
    // failures so far, read by the testbench at the end
    int fail_count = 0;

    // a stalled word stays on the bus unchanged
    stall_hold: assert property (@(posedge axis_aclk) disable iff (rst)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
    else
    begin
        fail_count++;
        $error("master word dropped or changed while tready was low");
    end

    // header word is never the last word
    user_last_apart: assert property (@(posedge axis_aclk) disable iff (rst)
        !(m_axis_tvalid && m_axis_tuser && m_axis_tlast))
    else
    begin
        fail_count++;
        $error("tuser and tlast both high on one word");
    end

    reset_not_ready: assert property (@(posedge axis_aclk) rst |-> !s_axis_tready)
    else
    begin
        fail_count++;
        $error("s_axis_tready high during reset");
    end

endmodule

bind mm_trigger_top mm_trigger_assert mm_trigger_assert_inst (
    .axis_aclk    (axis_aclk),
    .rst          (rst),
    .s_axis_tready(s_axis_tready),
    .m_axis_tdata (m_axis_tdata),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tready(m_axis_tready),
    .m_axis_tlast (m_axis_tlast),
    .m_axis_tuser (m_axis_tuser)
);

// ==== tests/mm_trigger_tb.sv ====
`timescale 1ns/10ps

module mm_trigger_tb;
    import adc_stream_pkg::*;

    localparam int THRESHOLD     = 400;
    localparam int BASELINE_LOG2 = 4;
    localparam int PRE_LEN       = 4;
    localparam int POST_LEN      = 6;
    localparam int FIFO_DEPTH    = 16;
    // noise after each pulse, enough to finish the capture and rearm
    localparam int TAIL_BEATS    = POST_LEN + 6;
    localparam int NUM_TESTS     = 9;

    localparam int READY_ALWAYS = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;

    typedef struct {
        string name;
        int    noise;
        int    height;
        int    width;
        int    gap;
        int    ready;
        bit    drop;
    } test_row_t;

    logic                    axis_aclk = 1'b0;
    logic                    rst;
    logic [S_DATA_WIDTH-1:0] s_axis_tdata;
    logic                    s_axis_tvalid;
    logic                    s_axis_tready;
    logic [M_DATA_WIDTH-1:0] m_axis_tdata;
    logic                    m_axis_tvalid;
    logic                    m_axis_tready;
    logic                    m_axis_tlast;
    logic                    m_axis_tuser;
    logic                    fifo_full;
    logic [15:0]             dropped_events;

    test_row_t               table_rows [NUM_TESTS];
    // every driven beat, position is the accepted beat index
    logic [S_DATA_WIDTH-1:0] beat_mem [$];
    logic [M_DATA_WIDTH-1:0] exp_data [$];
    logic                    exp_user [$];
    logic                    exp_last [$];
    int                      exp_test [$];
    int                      exp_word [$];
    logic [ADC_WIDTH-1:0]    exp_baseline;
    logic [31:0]             rnd;
    integer                  seed = 32'h6ff67cd6;
    int                      errors = 0;
    int                      tests_failed = 0;
    int                      exp_drops = 0;
    int                      event_count = 0;
    int                      ready_mode = READY_ALWAYS;
    int                      cycles = 0;
    int                      cycle_limit;

    always #50 axis_aclk = ~axis_aclk;

    mm_trigger_top #(
        .THRESHOLD    (THRESHOLD),
        .BASELINE_LOG2(BASELINE_LOG2),
        .PRE_LEN      (PRE_LEN),
        .POST_LEN     (POST_LEN),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) mm_trigger_top_inst (
        .axis_aclk     (axis_aclk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .fifo_full     (fifo_full),
        .dropped_events(dropped_events)
    );

    task automatic fill_table();
        table_rows[0] = '{"wide_pulse_first", 24, 1500, 20, 2, READY_ALWAYS, 1'b0};
        table_rows[1] = '{"rearm_after_wide", 20, 900, 1, 0, READY_ALWAYS, 1'b0};
        table_rows[2] = '{"sub_threshold", 20, 410, 1, 0, READY_ALWAYS, 1'b0};
        table_rows[3] = '{"post_window_gap", 20, 2000, 2, 3, READY_ALWAYS, 1'b0};
        table_rows[4] = '{"stall_single", 20, 1200, 1, 0, READY_RANDOM, 1'b0};
        table_rows[5] = '{"stall_wide_gap", 20, 3000, 8, 4, READY_RANDOM, 1'b0};
        table_rows[6] = '{"overflow_store", 20, 1000, 1, 0, READY_LOW, 1'b0};
        table_rows[7] = '{"overflow_drop", 20, 1100, 3, 0, READY_LOW, 1'b1};
        table_rows[8] = '{"overflow_drain", 40, 1300, 1, 1, READY_ALWAYS, 1'b0};
    endtask

    // noise alternates 10 and 12, a pulse puts its height in slot 3
    // the unused top bits of each slot carry the beat index
    function automatic logic [S_DATA_WIDTH-1:0] make_beat(input int idx, input int height);
        logic [S_DATA_WIDTH-1:0] beat;
        logic [ADC_WIDTH-1:0]    code;
        beat = '0;
        for (int s = 0; s < SAMPLES_PER_BEAT; s++)
        begin
            code = (s % 2 == 0) ? 12'd10 : 12'd12;
            if (height > 0 && s == 3)
                code = ADC_WIDTH'(height);
            else if (height > 0 && s == 6)
                code = ADC_WIDTH'(height / 2);
            beat[s*SLOT_WIDTH +: SLOT_WIDTH] = {(SLOT_WIDTH-ADC_WIDTH)'(idx + s), code};
        end
        return beat;
    endfunction

    function automatic logic [ADC_WIDTH-1:0] extreme_code(input logic [S_DATA_WIDTH-1:0] beat,
                                                         input bit want_max);
        logic [ADC_WIDTH-1:0] code;
        logic [ADC_WIDTH-1:0] best;
        best = beat[ADC_WIDTH-1:0];
        for (int s = 1; s < SAMPLES_PER_BEAT; s++)
        begin
            code = beat[s*SLOT_WIDTH +: ADC_WIDTH];
            if (want_max ? (code > best) : (code < best))
                best = code;
        end
        return best;
    endfunction

    // mean of the minima of the calibration beats
    function automatic logic [ADC_WIDTH-1:0] calib_baseline();
        int sum;
        sum = 0;
        for (int i = 0; i < 2**BASELINE_LOG2; i++)
            sum += extreme_code(beat_mem[i], 1'b0);
        return ADC_WIDTH'(sum >> BASELINE_LOG2);
    endfunction

    task automatic queue_word(input logic [M_DATA_WIDTH-1:0] data, input logic user,
                              input logic last, input int test, input int word);
        exp_data.push_back(data);
        exp_user.push_back(user);
        exp_last.push_back(last);
        exp_test.push_back(test);
        exp_word.push_back(word);
    endtask

    // header, then pre, trigger and post beats, low half first
    task automatic expect_event(input int trig, input int test);
        logic [S_DATA_WIDTH-1:0] beat;
        logic [M_DATA_WIDTH-1:0] hdr;
        int                      word;
        hdr = '0;
        hdr[15:0]  = trig[15:0];
        hdr[31:16] = event_count[15:0];
        hdr[43:32] = exp_baseline;
        queue_word(hdr, 1'b1, 1'b0, test, 1);
        word = 2;
        for (int i = trig - PRE_LEN; i <= trig + POST_LEN; i++)
        begin
            beat = beat_mem[i];
            queue_word(beat[63:0], 1'b0, 1'b0, test, word);
            queue_word(beat[127:64], 1'b0, i == trig + POST_LEN, test, word + 1);
            word += 2;
        end
        event_count++;
    endtask

    task automatic drive_beat(input logic [S_DATA_WIDTH-1:0] beat);
        @(negedge axis_aclk);
        s_axis_tdata  = beat;
        s_axis_tvalid = 1'b1;
    endtask

    task automatic drive_idle();
        @(negedge axis_aclk);
        s_axis_tvalid = 1'b0;
    endtask

    task automatic run_test(input int t);
        int first;
        int trig;
        int errs_before;
        errs_before = errors;
        ready_mode = table_rows[t].ready;
        first = beat_mem.size();
        for (int i = 0; i < table_rows[t].noise; i++)
            beat_mem.push_back(make_beat(beat_mem.size(), 0));
        trig = beat_mem.size();
        for (int i = 0; i < table_rows[t].width; i++)
            beat_mem.push_back(make_beat(beat_mem.size(), table_rows[t].height));
        for (int i = 0; i < TAIL_BEATS; i++)
            beat_mem.push_back(make_beat(beat_mem.size(), 0));
        if (t == 0)
            exp_baseline = calib_baseline();
        // first pulse beat above baseline plus threshold triggers
        if (extreme_code(beat_mem[trig], 1'b1) > exp_baseline + THRESHOLD)
        begin
            if (table_rows[t].drop)
                exp_drops++;
            else
                expect_event(trig, t);
        end
        for (int i = first; i < beat_mem.size(); i++)
        begin
            if (i == trig + table_rows[t].width)
                repeat (table_rows[t].gap) drive_idle();
            drive_beat(beat_mem[i]);
            // every driven beat must be taken
            if (s_axis_tready !== 1'b1)
            begin
                $display("Error %s s_axis_tready: expected 1, actual %b",
                         table_rows[t].name, s_axis_tready);
                errors++;
            end
        end
        drive_idle();
        if (ready_mode != READY_LOW)
        begin
            while (exp_data.size() != 0)
                @(posedge axis_aclk);
        end
        if (dropped_events !== 16'(exp_drops))
        begin
            $display("Error %s dropped_events: expected %0d, actual %0d",
                     table_rows[t].name, exp_drops, dropped_events);
            errors++;
        end
        // one stored event of 12 entries always leaves free space
        if (ready_mode == READY_LOW && fifo_full !== 1'b0)
        begin
            $display("Error %s fifo_full: expected 0, actual %b", table_rows[t].name, fifo_full);
            errors++;
        end
        if (errors != errs_before)
            tests_failed++;
        $display("test %0d %s: %s, %0d errors", t, table_rows[t].name,
                 (errors == errs_before) ? "passed" : "FAILED", errors - errs_before);
    endtask

    task automatic check_word();
        logic [M_DATA_WIDTH-1:0] e_data;
        logic                    e_user;
        logic                    e_last;
        int                      t;
        int                      w;
        e_data = exp_data.pop_front();
        e_user = exp_user.pop_front();
        e_last = exp_last.pop_front();
        t = exp_test.pop_front();
        w = exp_word.pop_front();
        if (m_axis_tdata !== e_data)
        begin
            $display("Error %s word %0d tdata: expected %h, actual %h",
                     table_rows[t].name, w, e_data, m_axis_tdata);
            errors++;
        end
        if (m_axis_tuser !== e_user)
        begin
            $display("Error %s word %0d tuser: expected %b, actual %b",
                     table_rows[t].name, w, e_user, m_axis_tuser);
            errors++;
        end
        if (m_axis_tlast !== e_last)
        begin
            $display("Error %s word %0d tlast: expected %b, actual %b",
                     table_rows[t].name, w, e_last, m_axis_tlast);
            errors++;
        end
    endtask

    // sink ready pattern
    always @(negedge axis_aclk)
    begin
        rnd = $random(seed);
        if (ready_mode == READY_RANDOM)
            m_axis_tready = rnd[0] | rnd[1];
        else
            m_axis_tready = (ready_mode == READY_ALWAYS);
    end

    always @(posedge axis_aclk)
    begin
        if (!rst && m_axis_tvalid && m_axis_tready)
        begin
            if (exp_data.size() == 0)
            begin
                $display("Unexpected output word %h arrived while no event was pending",
                         m_axis_tdata);
                errors++;
            end
            else
                check_word();
        end
    end

    always @(posedge axis_aclk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("Timeout after %0d cycles, expected output words never arrived", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        rst = 1'b1;
        s_axis_tdata = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
        fill_table();
        cycle_limit = 2000;
        for (int t = 0; t < NUM_TESTS; t++)
            cycle_limit += 4 * (table_rows[t].noise + table_rows[t].width
                                + table_rows[t].gap + TAIL_BEATS);
        repeat (10) @(posedge axis_aclk);
        @(negedge axis_aclk);
        rst = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 NUM_TESTS, tests_failed, errors,
                 mm_trigger_top_inst.mm_trigger_assert_inst.fail_count);
        if (errors == 0 && mm_trigger_top_inst.mm_trigger_assert_inst.fail_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== list.f ====
design/adc_stream_pkg.sv
design/trigger_ctrl_pkg.sv
design/baseline_tracker.sv
design/pretrigger_buffer.sv
design/trigger_sequencer.sv
design/event_packer.sv
design/mm_trigger_top.sv
tests/mm_trigger_assert.sv
tests/mm_trigger_tb.sv
